/* src/keypad_pkg.sv */
package keypad_pkg;

    // ============================================================
    // Sizes
    // ============================================================
    localparam int NUM_KEYS  = 10;
    localparam int NUM_PAGES = 5;
    localparam int ROW_LEN   = 16;

    typedef logic [7:0]           char_t;
    typedef logic [ROW_LEN*8-1:0] text_row_t;
    typedef logic [3:0]           col_t;
    typedef logic [2:0]           page_t;
    typedef logic [2:0]           key_idx_t;

    typedef enum logic [2:0] {
        KEY_NONE      = 3'd0,
        KEY_CHAR      = 3'd1,
        KEY_SPACE     = 3'd2,
        KEY_BACKSPACE = 3'd3,
        KEY_NEXT_PAGE = 3'd4,
        KEY_PREV_PAGE = 3'd5
    } key_kind_e;

    typedef struct packed {
        key_kind_e kind;
        key_idx_t  idx;
    } key_event_t;

    typedef struct packed {
        logic  row;
        col_t  col;
        char_t ch;
    } lcd_write_t;

    // ============================================================
    // Character tables
    // ============================================================
    localparam char_t CHAR_SPACE = 8'h20;

    // Eight characters per page, page 0 first
    localparam logic [NUM_PAGES*64-1:0] PAGE_CHARS =
        {"12345678", "9ABCDEF0", "GHIJKLMN", "OPQRSTUV", "WXYZ    "};

    // Columns 12 and 14 are patched with the page range
    localparam text_row_t STATUS_TEXT     = "ENCODER     x-y ";
    localparam col_t      STATUS_FIRST_COL = 4'd12;
    localparam col_t      STATUS_LAST_COL  = 4'd14;

    // Column 0 sits in the top byte, as in a string literal
    function automatic int col_lsb(col_t col);
        return (ROW_LEN - 1 - int'(col)) * 8;
    endfunction

    function automatic char_t row_char(text_row_t row, col_t col);
        return row[col_lsb(col) +: 8];
    endfunction

    function automatic char_t page_char(page_t page, key_idx_t idx);
        int pos;
        pos = int'(page) * 8 + int'(idx);
        return PAGE_CHARS[(NUM_PAGES * 8 - 1 - pos) * 8 +: 8];
    endfunction

endpackage

/* src/button_debouncer.sv */
`timescale 1ns/10ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync_q;
    logic             stable_q;
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], btn};
        end
    end

    // New level accepted after it held for the full window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable_q <= 1'b0;
            cnt_q    <= '0;
            press    <= 1'b0;
        end else begin
            press <= 1'b0;
            if (sync_q[1] == stable_q) begin
                cnt_q <= '0;
            end else if (cnt_q == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                stable_q <= sync_q[1];
                cnt_q    <= '0;
                press    <= sync_q[1];
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

/* src/key_decoder.sv */
`timescale 1ns/10ps

module key_decoder (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [keypad_pkg::NUM_KEYS-1:0]  key_in,
    input  logic                             active,
    output keypad_pkg::key_event_t           key_event
);

    // Bit positions of the special keys (key N is bit N-1)
    localparam int KEY7_BIT  = 6;
    localparam int KEY8_BIT  = 7;
    localparam int KEY9_BIT  = 8;
    localparam int KEY10_BIT = 9;

    logic [keypad_pkg::NUM_KEYS-1:0] sync1_q;
    logic [keypad_pkg::NUM_KEYS-1:0] sync2_q;
    logic [keypad_pkg::NUM_KEYS-1:0] prev_q;
    logic [keypad_pkg::NUM_KEYS-1:0] rise;
    logic [keypad_pkg::NUM_KEYS-1:0] fall;
    logic                            held9;
    logic                            combo_q;
    keypad_pkg::key_idx_t            low_idx;
    keypad_pkg::key_event_t          next_event;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= key_in;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise  = sync2_q & ~prev_q;
    assign fall  = ~sync2_q & prev_q;
    assign held9 = sync2_q[KEY9_BIT];

    // Lowest rising character key wins
    always_comb begin
        low_idx = '0;
        for (int i = 7; i >= 0; i--) begin
            if (rise[i]) begin
                low_idx = keypad_pkg::key_idx_t'(i);
            end
        end
    end

    always_comb begin
        next_event.kind = keypad_pkg::KEY_NONE;
        next_event.idx  = low_idx;
        if (!active) begin
            next_event.kind = keypad_pkg::KEY_NONE;
        end else if (rise[KEY10_BIT]) begin
            next_event.kind = keypad_pkg::KEY_BACKSPACE;
        end else if (fall[KEY9_BIT] && !combo_q) begin
            next_event.kind = keypad_pkg::KEY_SPACE;
        end else if (held9 && rise[KEY8_BIT]) begin
            next_event.kind = keypad_pkg::KEY_NEXT_PAGE;
        end else if (held9 && rise[KEY7_BIT]) begin
            next_event.kind = keypad_pkg::KEY_PREV_PAGE;
        end else if (!held9 && (rise[7:0] != 8'h00)) begin
            next_event.kind = keypad_pkg::KEY_CHAR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            combo_q        <= 1'b0;
            key_event.kind <= keypad_pkg::KEY_NONE;
            key_event.idx  <= '0;
        end else begin
            // Key 9 release ends the combination
            if (fall[KEY9_BIT]) begin
                combo_q <= 1'b0;
            end else if (held9 && (rise[KEY8_BIT] || rise[KEY7_BIT])) begin
                combo_q <= 1'b1;
            end
            key_event <= next_event;
        end
    end

endmodule

/* src/keymap_page.sv */
`timescale 1ns/10ps

module keymap_page (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   active,
    input  keypad_pkg::key_event_t key_event,
    output keypad_pkg::char_t      mapped_char,
    output keypad_pkg::text_row_t  status_row,
    output logic [7:0]             led_out
);

    localparam keypad_pkg::page_t LAST_PAGE =
        keypad_pkg::page_t'(keypad_pkg::NUM_PAGES - 1);

    keypad_pkg::page_t    page_q;
    keypad_pkg::key_idx_t last_idx;

    // ============================================================
    // Page register and LEDs
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page_q  <= '0;
            led_out <= 8'h00;
        end else begin
            if (active) begin
                case (key_event.kind)
                    keypad_pkg::KEY_NEXT_PAGE: begin
                        page_q <= (page_q == LAST_PAGE) ? '0 : page_q + 1'b1;
                    end
                    keypad_pkg::KEY_PREV_PAGE: begin
                        page_q <= (page_q == '0) ? LAST_PAGE : page_q - 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            if (!active) begin
                led_out <= 8'h00;
            end else if (page_q == LAST_PAGE) begin
                led_out <= 8'h0F;
            end else begin
                led_out <= 8'hFF;
            end
        end
    end

    // ============================================================
    // Lookups
    // ============================================================
    assign mapped_char = keypad_pkg::page_char(page_q, key_event.idx);

    // Last page carries only four characters
    assign last_idx = (page_q == LAST_PAGE) ? 3'd3 : 3'd7;

    always_comb begin
        status_row = keypad_pkg::STATUS_TEXT;
        status_row[keypad_pkg::col_lsb(keypad_pkg::STATUS_FIRST_COL) +: 8] =
            keypad_pkg::page_char(page_q, 3'd0);
        status_row[keypad_pkg::col_lsb(keypad_pkg::STATUS_LAST_COL) +: 8] =
            keypad_pkg::page_char(page_q, last_idx);
    end

endmodule

/* src/text_editor.sv */
`timescale 1ns/10ps

module text_editor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   active,
    input  keypad_pkg::key_event_t key_event,
    input  keypad_pkg::char_t      mapped_char,
    input  logic                   clear,
    output keypad_pkg::text_row_t  text_row,
    output logic                   refresh
);

    localparam keypad_pkg::col_t LAST_COL = 4'd15;

    keypad_pkg::col_t  cursor_q;
    keypad_pkg::col_t  length_q;
    keypad_pkg::col_t  next_col;
    keypad_pkg::col_t  prev_col;
    keypad_pkg::char_t new_char;
    logic              active_q;

    always_comb begin
        next_col = cursor_q + 1'b1;
        prev_col = cursor_q - 1'b1;
        if (key_event.kind == keypad_pkg::KEY_CHAR) begin
            new_char = mapped_char;
        end else begin
            new_char = keypad_pkg::CHAR_SPACE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            text_row <= {keypad_pkg::ROW_LEN{keypad_pkg::CHAR_SPACE}};
            cursor_q <= '0;
            length_q <= '0;
            active_q <= 1'b0;
            refresh  <= 1'b0;
        end else begin
            refresh  <= 1'b0;
            active_q <= active;

            // Screen must be redrawn when the panel wakes up
            if (active && !active_q) begin
                refresh <= 1'b1;
            end

            if (active) begin
                case (key_event.kind)
                    keypad_pkg::KEY_CHAR, keypad_pkg::KEY_SPACE: begin
                        text_row[keypad_pkg::col_lsb(cursor_q) +: 8] <= new_char;
                        if (cursor_q != LAST_COL) begin
                            cursor_q <= next_col;
                            if (next_col > length_q) begin
                                length_q <= next_col;
                            end
                        end else begin
                            // Last cell is overwritten in place
                            length_q <= LAST_COL;
                        end
                        refresh <= 1'b1;
                    end
                    keypad_pkg::KEY_BACKSPACE: begin
                        if (cursor_q != '0) begin
                            cursor_q <= prev_col;
                            text_row[keypad_pkg::col_lsb(prev_col) +: 8] <=
                                keypad_pkg::CHAR_SPACE;
                            if (length_q != '0) begin
                                length_q <= length_q - 1'b1;
                            end
                            refresh <= 1'b1;
                        end
                    end
                    keypad_pkg::KEY_NEXT_PAGE, keypad_pkg::KEY_PREV_PAGE: begin
                        refresh <= 1'b1;
                    end
                    default: begin
                    end
                endcase

                if (clear) begin
                    text_row <= {keypad_pkg::ROW_LEN{keypad_pkg::CHAR_SPACE}};
                    cursor_q <= '0;
                    length_q <= '0;
                    refresh  <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/lcd_refresh.sv */
`timescale 1ns/10ps

module lcd_refresh (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  refresh,
    input  keypad_pkg::text_row_t text_row,
    input  keypad_pkg::text_row_t status_row,
    input  logic                  lcd_busy,
    input  logic                  lcd_done,
    output logic                  lcd_req,
    output keypad_pkg::lcd_write_t lcd_write
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_WAIT
    } state_e;

    state_e                 state_q;
    logic                   row_q;
    keypad_pkg::col_t       col_q;
    keypad_pkg::lcd_write_t cur_write;
    keypad_pkg::lcd_write_t held_q;

    // Cell under the walk pointer, sampled from the live rows
    always_comb begin
        cur_write.row = row_q;
        cur_write.col = col_q;
        if (row_q) begin
            cur_write.ch = keypad_pkg::row_char(status_row, col_q);
        end else begin
            cur_write.ch = keypad_pkg::row_char(text_row, col_q);
        end
    end

    assign lcd_req   = (state_q == ST_WRITE) && !lcd_busy;
    assign lcd_write = (state_q == ST_WRITE) ? cur_write : held_q;

    // ============================================================
    // Frame walk, row 0 then row 1
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            row_q   <= 1'b0;
            col_q   <= '0;
            held_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (refresh) begin
                        row_q   <= 1'b0;
                        col_q   <= '0;
                        state_q <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (lcd_req) begin
                        held_q  <= cur_write;
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (lcd_done) begin
                        col_q <= col_q + 1'b1;
                        if (col_q == 4'd15) begin
                            row_q   <= 1'b1;
                            state_q <= row_q ? ST_IDLE : ST_WRITE;
                        end else begin
                            state_q <= ST_WRITE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

/* src/keypad_ui_top.sv */
`timescale 1ns/10ps

module keypad_ui_top #(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            is_active,
    input  logic [keypad_pkg::NUM_KEYS-1:0] key_in,
    input  logic                            btn_clear,
    input  logic                            lcd_busy,
    input  logic                            lcd_done,
    output logic                            lcd_req,
    output logic                            lcd_row,
    output keypad_pkg::col_t                lcd_col,
    output keypad_pkg::char_t               lcd_char,
    output logic [7:0]                      led_out
);

    keypad_pkg::key_event_t key_event;
    keypad_pkg::char_t      mapped_char;
    keypad_pkg::text_row_t  text_row;
    keypad_pkg::text_row_t  status_row;
    keypad_pkg::lcd_write_t lcd_write;
    logic                   clear_press;
    logic                   refresh;

    button_debouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) button_debouncer_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .btn  (btn_clear),
        .press(clear_press)
    );

    key_decoder key_decoder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_in   (key_in),
        .active   (is_active),
        .key_event(key_event)
    );

    keymap_page keymap_page_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (is_active),
        .key_event  (key_event),
        .mapped_char(mapped_char),
        .status_row (status_row),
        .led_out    (led_out)
    );

    text_editor text_editor_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (is_active),
        .key_event  (key_event),
        .mapped_char(mapped_char),
        .clear      (clear_press),
        .text_row   (text_row),
        .refresh    (refresh)
    );

    lcd_refresh lcd_refresh_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .refresh   (refresh),
        .text_row  (text_row),
        .status_row(status_row),
        .lcd_busy  (lcd_busy),
        .lcd_done  (lcd_done),
        .lcd_req   (lcd_req),
        .lcd_write (lcd_write)
    );

    // LCD port fields
    assign lcd_row  = lcd_write.row;
    assign lcd_col  = lcd_write.col;
    assign lcd_char = lcd_write.ch;

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* test/tb_keypad_ui.sv */
`timescale 1ns/10ps

module tb_keypad_ui;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int DEBOUNCE      = 4;
    localparam int HOLD_CYCLES   = 5;
    localparam int IDLE_CYCLES   = 10;
    localparam logic [31:0] SEED = 32'hbfa8d8bc;
    // About 60 actions of at most ~290 cycles each, with margin
    localparam int MAX_CYCLES    = 20000;

    logic       clk;
    logic       rst_n;
    logic       is_active;
    logic [9:0] key_in;
    logic       btn_clear;
    logic       lcd_busy;
    logic       lcd_done;
    logic       lcd_req;
    logic       lcd_row;
    logic [3:0] lcd_col;
    logic [7:0] lcd_char;
    logic [7:0] led_out;

    // LCD screen as written by the DUT, and the write walk position
    logic [7:0] screen [2][16];
    logic       pending;
    int         exp_row;
    int         exp_col;
    int         frame_count;

    // Reference model of the panel
    logic [7:0] exp_text [16];
    int         cursor;
    int         length;
    int         page;
    string      page_text [5] = '{"12345678", "9ABCDEF0", "GHIJKLMN", "OPQRSTUV", "WXYZ    "};

    tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_inst (.clk(clk));

    keypad_ui_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE)
    ) keypad_ui_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .is_active(is_active),
        .key_in   (key_in),
        .btn_clear(btn_clear),
        .lcd_busy (lcd_busy),
        .lcd_done (lcd_done),
        .lcd_req  (lcd_req),
        .lcd_row  (lcd_row),
        .lcd_col  (lcd_col),
        .lcd_char (lcd_char),
        .led_out  (led_out)
    );

    // ============================================================
    // Failure reporting
    // ============================================================
    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    initial begin : cycle_limit
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        report_failure("Cycle limit reached before the tests finished");
    end

    // ============================================================
    // LCD responder
    // ============================================================
    initial begin : lcd_responder
        int         delay;
        int         recover;
        logic       held_row;
        logic [3:0] held_col;
        logic [7:0] held_char;
        delay       = 0;
        recover     = 0;
        held_row    = 1'b0;
        held_col    = '0;
        held_char   = '0;
        lcd_busy    = 1'b0;
        lcd_done    = 1'b0;
        pending     = 1'b0;
        exp_row     = 0;
        exp_col     = 0;
        frame_count = 0;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 16; c++) begin
                screen[r][c] = 8'h00;
            end
        end
        forever begin
            @(negedge clk);
            if (pending && delay > 0) begin
                lcd_busy = 1'b1;
                lcd_done = 1'b0;
                delay    = delay - 1;
            end else if (pending) begin
                lcd_busy = 1'b0;
                lcd_done = 1'b1;
            end else if (recover > 0) begin
                // Display still busy a little after each write
                lcd_busy = 1'b1;
                lcd_done = 1'b0;
                recover  = recover - 1;
            end else begin
                lcd_busy = 1'b0;
                lcd_done = 1'b0;
            end
            // Middle of the low phase, all DUT outputs settled
            #(CLK_PERIOD / 4);
            if (pending) begin
                assert (lcd_row == held_row) else
                    report_mismatch("lcd_row", 32'(lcd_row), 32'(held_row));
                assert (lcd_col == held_col) else
                    report_mismatch("lcd_col", 32'(lcd_col), 32'(held_col));
                assert (lcd_char == held_char) else
                    report_mismatch("lcd_char", 32'(lcd_char), 32'(held_char));
            end
            if (lcd_done) begin
                pending = 1'b0;
                recover = int'($urandom % 4);
            end
            if (lcd_req) begin
                assert (!lcd_busy) else report_failure("lcd_req raised while lcd_busy was high");
                assert (!pending && !lcd_done) else
                    report_failure("Second lcd_req before lcd_done");
                assert (32'(lcd_row) == 32'(exp_row)) else
                    report_mismatch("lcd_row", 32'(lcd_row), 32'(exp_row));
                assert (32'(lcd_col) == 32'(exp_col)) else
                    report_mismatch("lcd_col", 32'(lcd_col), 32'(exp_col));
                screen[lcd_row][lcd_col] = lcd_char;
                held_row  = lcd_row;
                held_col  = lcd_col;
                held_char = lcd_char;
                pending   = 1'b1;
                delay     = int'($urandom % 4);
                exp_col++;
                if (exp_col == 16) begin
                    exp_col = 0;
                    if (exp_row == 1) begin
                        exp_row = 0;
                        frame_count++;
                    end else begin
                        exp_row = 1;
                    end
                end
            end
        end
    end

    // ============================================================
    // Reference model
    // ============================================================
    function automatic void enter_char(logic [7:0] ch);
        exp_text[cursor] = ch;
        if (cursor < 15) begin
            cursor++;
            if (cursor > length) begin
                length = cursor;
            end
        end else begin
            length = 15;
        end
    endfunction

    function automatic void erase_char();
        if (cursor > 0) begin
            cursor--;
            exp_text[cursor] = " ";
            length--;
        end
    endfunction

    function automatic void clear_text();
        for (int c = 0; c < 16; c++) begin
            exp_text[c] = " ";
        end
        cursor = 0;
        length = 0;
    endfunction

    function automatic logic [7:0] status_char_at(int col);
        string tmpl;
        tmpl = "ENCODER     x-y ";
        if (col == 12) begin
            return page_text[page][0];
        end
        if (col == 14) begin
            return page_text[page][(page == 4) ? 3 : 7];
        end
        return tmpl[col];
    endfunction

    function automatic logic [7:0] expected_led();
        if (!is_active) begin
            return 8'h00;
        end
        if (page == 4) begin
            return 8'h0F;
        end
        return 8'hFF;
    endfunction

    function automatic int random_key();
        int r;
        r = int'($urandom % 12);
        if (r < 8) begin
            return r + 1;
        end else if (r < 10) begin
            return 9;
        end
        return 10;
    endfunction

    // ============================================================
    // Stimulus helpers
    // ============================================================
    // End of the running frame and then a quiet stretch
    task automatic settle();
        int quiet;
        quiet = 0;
        while (quiet < IDLE_CYCLES) begin
            @(negedge clk);
            if (pending || exp_row != 0 || exp_col != 0) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic check_screen();
        for (int c = 0; c < 16; c++) begin
            assert (screen[0][c] == exp_text[c]) else
                report_mismatch($sformatf("lcd row 0 col %0d", c),
                                32'(screen[0][c]), 32'(exp_text[c]));
            assert (screen[1][c] == status_char_at(c)) else
                report_mismatch($sformatf("lcd row 1 col %0d", c),
                                32'(screen[1][c]), 32'(status_char_at(c)));
        end
        assert (led_out == expected_led()) else
            report_mismatch("led_out", 32'(led_out), 32'(expected_led()));
    endtask

    // Key k is 1 to 10
    task automatic tap_key(int k);
        key_in[k-1] = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        key_in[k-1] = 1'b0;
        if (is_active) begin
            if (k <= 8) begin
                enter_char(page_text[page][k-1]);
            end else if (k == 9) begin
                enter_char(" ");
            end else begin
                erase_char();
            end
        end
        settle();
        check_screen();
    endtask

    // Key 9 held with key 8 goes forward, with key 7 back
    task automatic flip_page(bit forward);
        key_in[8] = 1'b1;
        repeat (3) @(negedge clk);
        key_in[forward ? 7 : 6] = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        key_in[forward ? 7 : 6] = 1'b0;
        repeat (3) @(negedge clk);
        key_in[8] = 1'b0;
        if (is_active) begin
            page = forward ? (page + 1) % 5 : (page + 4) % 5;
        end
        settle();
        check_screen();
    endtask

    task automatic press_clear();
        btn_clear = 1'b1;
        repeat (DEBOUNCE + 6) @(negedge clk);
        btn_clear = 1'b0;
        if (is_active) begin
            clear_text();
        end
        settle();
        check_screen();
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin : stimulus
        int frames_before;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        is_active = 1'b0;
        key_in    = '0;
        btn_clear = 1'b0;
        page      = 0;
        clear_text();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        assert (lcd_req == 1'b0) else report_mismatch("lcd_req", 32'(lcd_req), 32'h0);
        assert (led_out == 8'h00) else report_mismatch("led_out", 32'(led_out), 32'h0);
        assert (frame_count == 0) else report_failure("LCD written before is_active rose");

        // Wake-up frame
        is_active = 1'b1;
        settle();
        assert (frame_count == 1) else report_failure("Raising is_active drew no single frame");
        check_screen();

        // Editing, backspace at column 0 first
        tap_key(10);
        repeat (30) tap_key(random_key());
        press_clear();

        // Paging with wrap in both directions
        for (int i = 0; i < 6; i++) begin
            flip_page(1'b1);
            tap_key(1 + i);
        end
        for (int i = 0; i < 3; i++) begin
            flip_page(1'b0);
            tap_key(3 + i);
        end
        tap_key(9);

        // Panel asleep
        is_active = 1'b0;
        settle();
        check_screen();
        frames_before = frame_count;
        tap_key(2);
        tap_key(9);
        tap_key(10);
        flip_page(1'b1);
        press_clear();
        assert (frame_count == frames_before) else
            report_failure("LCD written while is_active was low");

        is_active = 1'b1;
        settle();
        assert (frame_count == frames_before + 1) else
            report_failure("No frame drawn when is_active rose again");
        check_screen();

        $display("No errors");
        $finish;
    end

endmodule

/* compile.f */
src/keypad_pkg.sv
src/button_debouncer.sv
src/key_decoder.sv
src/keymap_page.sv
src/text_editor.sv
src/lcd_refresh.sv
src/keypad_ui_top.sv
test/tb_clock.sv
test/tb_keypad_ui.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_keypad_ui
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
